//--- common/pwo_pkg.sv
// ==================================================
// Pointwise engine constants, coefficient and memory
// word types, memory request struct and mode enum
// ==================================================

package pwo_pkg;

    // ==================================================
    // Field and polynomial constants
    // ==================================================

    localparam int COEFF_WIDTH   = 23;
    localparam int SLOT_WIDTH    = 24;
    localparam int COEFF_PER_CLK = 4;
    localparam int NUM_BEATS     = 64;

    // Operands in to result out, per lane
    localparam int LANE_LATENCY  = 2;

    // q = 2^23 - 2^13 + 1
    localparam logic [COEFF_WIDTH-1:0] MLDSA_Q = 23'd8380417;

    // Address width carried by every memory request
    localparam int MEM_ADDR_WIDTH = 8;

    // ==================================================
    // Data types
    // ==================================================

    typedef logic [COEFF_WIDTH-1:0] coeff_t;

    // One slot of a memory word, pad bit on top
    typedef struct packed {
        logic [SLOT_WIDTH-COEFF_WIDTH-1:0] pad;
        coeff_t                            coeff;
    } slot_t;

    // Four slots, slot 0 sits in the low bits
    typedef struct packed {
        slot_t [COEFF_PER_CLK-1:0] slot;
    } mem_word_t;

    // Fourth code is reserved
    typedef enum logic [1:0] {
        mode_pwm = 2'b00,
        mode_pwa = 2'b01,
        mode_pws = 2'b10
    } pwo_mode_e;

    // Read or write request to one memory port
    typedef struct packed {
        logic                      en;
        logic [MEM_ADDR_WIDTH-1:0] addr;
    } mem_req_t;

endpackage

//--- verilog/pwo_delay.sv
// ==================================================
// Fixed-depth delay line for any payload type
// ==================================================

module pwo_delay #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
)
(
    input  logic clk,
    input  logic reset_n,
    input  T     d_i,
    output T     q_o
);

    T pipe [DEPTH];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= d_i;
            for (int i = 1; i < DEPTH; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    // Oldest stage
    assign q_o = pipe[DEPTH-1];

endmodule

//--- pwo/pwo_lane.sv
// ==================================================
// Two-stage modular multiply, add, subtract and
// accumulate for one coefficient
// ==================================================

module pwo_lane
    import pwo_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  pwo_mode_e mode_i,
    input  logic      acc_i,
    // Operands are expected below q
    input  coeff_t    a_i,
    input  coeff_t    b_i,
    input  coeff_t    c_i,
    output coeff_t    r_o
);

    localparam int PROD_WIDTH = 2 * COEFF_WIDTH;
    localparam int SUM_WIDTH  = COEFF_WIDTH + 1;
    // 2^23 = 2^13 - 1 (mod q)
    localparam int Q_SHIFT    = 13;

    localparam logic [SUM_WIDTH-1:0]  Q_SUM  = SUM_WIDTH'(MLDSA_Q);
    localparam logic [PROD_WIDTH-1:0] Q_PROD = PROD_WIDTH'(MLDSA_Q);

    // Replace hi * 2^23 by hi * (2^13 - 1), never negative
    function automatic logic [PROD_WIDTH-1:0] fold(input logic [PROD_WIDTH-1:0] x);
        logic [PROD_WIDTH-1:0] hi;
        logic [PROD_WIDTH-1:0] lo;
        hi = PROD_WIDTH'(x[PROD_WIDTH-1:COEFF_WIDTH]);
        lo = PROD_WIDTH'(x[COEFF_WIDTH-1:0]);
        return (hi << Q_SHIFT) - hi + lo;
    endfunction

    // Input below 2q
    function automatic coeff_t cond_sub(input logic [SUM_WIDTH-1:0] x);
        logic [SUM_WIDTH-1:0] d;
        d = x - Q_SUM;
        return (x >= Q_SUM) ? d[COEFF_WIDTH-1:0] : x[COEFF_WIDTH-1:0];
    endfunction

    // ==================================================
    // Stage 1: product, sum or difference
    // ==================================================

    logic [PROD_WIDTH-1:0] s1_val;
    coeff_t                s1_c;
    pwo_mode_e             s1_mode;

    always_ff @(posedge clk) begin
        case (mode_i)
            mode_pwm: s1_val <= PROD_WIDTH'(a_i) * PROD_WIDTH'(b_i);
            mode_pwa: s1_val <= PROD_WIDTH'(a_i) + PROD_WIDTH'(b_i);
            // Bias by q so the difference stays positive
            default:  s1_val <= PROD_WIDTH'(a_i) + Q_PROD - PROD_WIDTH'(b_i);
        endcase
        s1_c <= (acc_i && (mode_i == mode_pwm)) ? c_i : '0;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_mode <= mode_pwm;
        end else begin
            s1_mode <= mode_i;
        end
    end

    // ==================================================
    // Stage 2: reduction and accumulate
    // ==================================================

    logic [PROD_WIDTH-1:0] folded;
    logic [SUM_WIDTH-1:0]  pre_red;
    coeff_t                red;
    logic [SUM_WIDTH-1:0]  acc_sum;

    always_comb begin
        // Three folds bring a product below 2^23 + 2^18
        folded  = fold(fold(fold(s1_val)));
        pre_red = (s1_mode == mode_pwm) ? folded[SUM_WIDTH-1:0] : s1_val[SUM_WIDTH-1:0];
        red     = cond_sub(pre_red);
        acc_sum = SUM_WIDTH'(red) + SUM_WIDTH'(s1_c);
    end

    always_ff @(posedge clk) begin
        r_o <= cond_sub(acc_sum);
    end

endmodule

//--- pwo/pwo_ctrl.sv
// ==================================================
// Pointwise controller: beat counter, memory address
// generation and busy/done sequencing
// ==================================================

module pwo_ctrl
    import pwo_pkg::*;
#(
    parameter int ADDR_WIDTH = MEM_ADDR_WIDTH
)
(
    input  logic                  clk,
    input  logic                  reset_n,

    // Operation request
    input  logic                  start_i,
    input  pwo_mode_e             mode_i,
    input  logic                  accumulate_i,
    input  logic [ADDR_WIDTH-1:0] base_a_i,
    input  logic [ADDR_WIDTH-1:0] base_b_i,
    input  logic [ADDR_WIDTH-1:0] base_c_i,

    // Aligned done from the write-side delay line
    input  logic                  done_i,

    output mem_req_t              rd_a_req_o,
    output mem_req_t              rd_b_req_o,
    output mem_req_t              rd_c_req_o,
    output mem_req_t              wr_c_req_o,
    output pwo_mode_e             op_mode_o,
    output logic                  op_acc_o,
    output logic                  busy_o,
    output logic                  done_o
);

    typedef enum logic {
        st_idle,
        st_run
    } ctrl_state_e;

    localparam logic [5:0] LAST_BEAT = 6'(NUM_BEATS - 1);

    ctrl_state_e           state;
    logic [5:0]            beat_cnt;
    logic                  busy_q;
    logic                  done_q;
    logic                  start_ok;
    logic                  run;
    pwo_mode_e             op_mode_q;
    logic                  op_acc_q;
    logic [ADDR_WIDTH-1:0] base_a_q;
    logic [ADDR_WIDTH-1:0] base_b_q;
    logic [ADDR_WIDTH-1:0] base_c_q;

    if (ADDR_WIDTH > MEM_ADDR_WIDTH) begin : g_addr_check
        $error("pwo_ctrl: ADDR_WIDTH exceeds MEM_ADDR_WIDTH");
    end

    // Address for one beat, wraps inside ADDR_WIDTH
    function automatic mem_req_t make_req(input logic en,
                                          input logic [ADDR_WIDTH-1:0] base,
                                          input logic [5:0] beat);
        mem_req_t req;
        req.en   = en;
        req.addr = MEM_ADDR_WIDTH'(base + ADDR_WIDTH'(beat));
        return req;
    endfunction

    // Busy drops in the cycle the aligned done shows up
    assign busy_o   = busy_q & ~done_i;
    assign start_ok = start_i & ~busy_o;
    assign run      = (state == st_run);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= st_idle;
            beat_cnt  <= '0;
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
            op_mode_q <= mode_pwm;
            op_acc_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                st_idle: begin
                    if (start_ok) begin
                        state     <= st_run;
                        beat_cnt  <= '0;
                        op_mode_q <= mode_i;
                        op_acc_q  <= accumulate_i;
                    end
                end
                default: begin
                    beat_cnt <= beat_cnt + 6'd1;
                    if (beat_cnt == LAST_BEAT) begin
                        state  <= st_idle;
                        done_q <= 1'b1;
                    end
                end
            endcase
            if (start_ok) begin
                busy_q <= 1'b1;
            end else if (done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Base addresses held for the whole operation
    always_ff @(posedge clk) begin
        if (start_ok) begin
            base_a_q <= base_a_i;
            base_b_q <= base_b_i;
            base_c_q <= base_c_i;
        end
    end

    assign rd_a_req_o = make_req(run, base_a_q, beat_cnt);
    assign rd_b_req_o = make_req(run, base_b_q, beat_cnt);
    // c is only read back when accumulating a product
    assign rd_c_req_o = make_req(run && (op_mode_q == mode_pwm) && op_acc_q, base_c_q, beat_cnt);
    assign wr_c_req_o = make_req(run, base_c_q, beat_cnt);

    assign op_mode_o = op_mode_q;
    assign op_acc_o  = op_acc_q;
    assign done_o    = done_q;

endmodule

//--- verilog/pwo_top.sv
// ==================================================
// Pointwise engine top: controller, four lanes and
// write-side alignment to the memory ports
// ==================================================

module pwo_top
    import pwo_pkg::*;
#(
    parameter int ADDR_WIDTH = MEM_ADDR_WIDTH
)
(
    input  logic                  clk,
    input  logic                  reset_n,

    input  logic                  start_i,
    input  pwo_mode_e             mode_i,
    input  logic                  accumulate_i,
    input  logic [ADDR_WIDTH-1:0] base_a_i,
    input  logic [ADDR_WIDTH-1:0] base_b_i,
    input  logic [ADDR_WIDTH-1:0] base_c_i,

    // Memory ports, one cycle read latency
    output mem_req_t              rd_a_req_o,
    output mem_req_t              rd_b_req_o,
    output mem_req_t              rd_c_req_o,
    input  mem_word_t             rd_a_data_i,
    input  mem_word_t             rd_b_data_i,
    input  mem_word_t             rd_c_data_i,
    output mem_req_t              wr_req_o,
    output mem_word_t             wr_data_o,

    output logic                  busy_o,
    output logic                  done_o
);

    // Read latency plus lane latency
    localparam int WR_ALIGN_DEPTH = LANE_LATENCY + 1;

    mem_req_t  wr_c_req;
    pwo_mode_e op_mode;
    logic      op_acc;
    logic      ctrl_done;
    logic      done_aligned;
    coeff_t    lane_res [COEFF_PER_CLK];

    pwo_ctrl #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) ctrl_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .start_i      (start_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .base_a_i     (base_a_i),
        .base_b_i     (base_b_i),
        .base_c_i     (base_c_i),
        .done_i       (done_aligned),
        .rd_a_req_o   (rd_a_req_o),
        .rd_b_req_o   (rd_b_req_o),
        .rd_c_req_o   (rd_c_req_o),
        .wr_c_req_o   (wr_c_req),
        .op_mode_o    (op_mode),
        .op_acc_o     (op_acc),
        .busy_o       (busy_o),
        .done_o       (ctrl_done)
    );

    // Read data goes straight into the lanes
    for (genvar i = 0; i < COEFF_PER_CLK; i++) begin : g_lane
        pwo_lane lane_inst (
            .clk     (clk),
            .reset_n (reset_n),
            .mode_i  (op_mode),
            .acc_i   (op_acc),
            .a_i     (rd_a_data_i.slot[i].coeff),
            .b_i     (rd_b_data_i.slot[i].coeff),
            .c_i     (rd_c_data_i.slot[i].coeff),
            .r_o     (lane_res[i])
        );
    end

    // Repack results with zero pad bits
    always_comb begin
        for (int i = 0; i < COEFF_PER_CLK; i++) begin
            wr_data_o.slot[i].pad   = '0;
            wr_data_o.slot[i].coeff = lane_res[i];
        end
    end

    // ==================================================
    // Write-side alignment
    // ==================================================

    pwo_delay #(.T(mem_req_t), .DEPTH(WR_ALIGN_DEPTH)) wr_req_delay_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .d_i     (wr_c_req),
        .q_o     (wr_req_o)
    );

    pwo_delay #(.T(logic), .DEPTH(WR_ALIGN_DEPTH)) done_delay_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .d_i     (ctrl_done),
        .q_o     (done_aligned)
    );

    assign done_o = done_aligned;

endmodule

//--- test/pwo_asserts.sv
// ==================================================
// Protocol assertions for the pointwise engine top
// ==================================================

module pwo_asserts
    import pwo_pkg::*;
(
    input logic      clk,
    input logic      reset_n,
    input logic      start_i,
    input pwo_mode_e mode_i,
    input logic      busy_i,
    input logic      done_i,
    input mem_req_t  wr_req_i
);

    // Every write belongs to a running operation
    write_needs_busy: assert property (
        @(posedge clk) disable iff (!reset_n) wr_req_i.en |-> busy_i
    ) else $error("write request while busy is low");

    // Done only ends a busy period and never overlaps busy
    done_ends_busy: assert property (
        @(posedge clk) disable iff (!reset_n) done_i |-> ($past(busy_i) && !busy_i)
    ) else $error("done without a preceding busy period or with busy still high");

    // Reserved mode code never accepted
    start_mode_valid: assert property (
        @(posedge clk) disable iff (!reset_n)
        (start_i && !busy_i) |-> (mode_i inside {mode_pwm, mode_pwa, mode_pws})
    ) else $error("start with the unused mode code");

endmodule

bind pwo_top pwo_asserts pwo_asserts_inst (
    .clk      (clk),
    .reset_n  (reset_n),
    .start_i  (start_i),
    .mode_i   (mode_i),
    .busy_i   (busy_o),
    .done_i   (done_o),
    .wr_req_i (wr_req_o)
);

//--- test/pwo_tb.sv
// ==================================================
// Pointwise engine testbench: memory models, LCG,
// directed tests, watchdog and summary
// ==================================================

module pwo_tb
    import pwo_pkg::*;
();

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 8;
    localparam int NUM_TESTS       = 5;
    localparam int OP_CYCLES       = 68;
    localparam int DONE_TIMEOUT    = 100;
    localparam int WATCHDOG_CYCLES = 6 * 80 + RESET_CYCLES;
    localparam logic [7:0] BASE_A  = 8'd0;
    localparam logic [7:0] BASE_B  = 8'd64;
    localparam logic [7:0] BASE_C  = 8'd128;

    logic       clk = 1'b0;
    logic       reset_n;
    logic       start;
    pwo_mode_e  mode;
    logic       accumulate;
    logic [7:0] base_a;
    logic [7:0] base_b;
    logic [7:0] base_c;
    mem_req_t   rd_a_req;
    mem_req_t   rd_b_req;
    mem_req_t   rd_c_req;
    mem_word_t  rd_a_data = '0;
    mem_word_t  rd_b_data = '0;
    mem_word_t  rd_c_data = '0;
    mem_req_t   wr_req;
    mem_word_t  wr_data;
    logic       busy;
    logic       done;

    mem_word_t  mem_a [256];
    mem_word_t  mem_b [256];
    mem_word_t  mem_c [256];
    // Snapshot of c taken at start, for accumulate checks
    mem_word_t  mem_c_old [256];

    logic [31:0] lcg_state = 32'd94;
    int          error_count = 0;
    int          failed_tests = 0;
    // Enabled c read requests seen by the memory model
    int          rd_c_count = 0;

    pwo_top #(
        .ADDR_WIDTH(MEM_ADDR_WIDTH)
    ) pwo_top_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .start_i      (start),
        .mode_i       (mode),
        .accumulate_i (accumulate),
        .base_a_i     (base_a),
        .base_b_i     (base_b),
        .base_c_i     (base_c),
        .rd_a_req_o   (rd_a_req),
        .rd_b_req_o   (rd_b_req),
        .rd_c_req_o   (rd_c_req),
        .rd_a_data_i  (rd_a_data),
        .rd_b_data_i  (rd_b_data),
        .rd_c_data_i  (rd_c_data),
        .wr_req_o     (wr_req),
        .wr_data_o    (wr_data),
        .busy_o       (busy),
        .done_o       (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Memories answer one cycle after an enabled request
    always @(posedge clk) begin
        if (rd_a_req.en) begin
            rd_a_data <= mem_a[rd_a_req.addr];
        end
        if (rd_b_req.en) begin
            rd_b_data <= mem_b[rd_b_req.addr];
        end
        if (rd_c_req.en) begin
            rd_c_data  <= mem_c[rd_c_req.addr];
            rd_c_count <= rd_c_count + 1;
        end
        if (wr_req.en) begin
            mem_c[wr_req.addr] <= wr_data;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic coeff_t rand_coeff();
        return coeff_t'((lcg_next() >> 4) % 32'(MLDSA_Q));
    endfunction

    // Reference result from the modular rules
    function automatic coeff_t expected_coeff(input pwo_mode_e m, input logic acc,
                                              input coeff_t a, input coeff_t b,
                                              input coeff_t c);
        logic [63:0] q64;
        logic [63:0] r;
        q64 = 64'(MLDSA_Q);
        case (m)
            mode_pwm: begin
                r = (64'(a) * 64'(b)) % q64;
                if (acc) begin
                    r = (r + 64'(c)) % q64;
                end
            end
            mode_pwa: r = (64'(a) + 64'(b)) % q64;
            default:  r = (64'(a) + q64 - 64'(b)) % q64;
        endcase
        return coeff_t'(r);
    endfunction

    task automatic report_error(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic finish_test(input string name, input int start_errors);
        int errs;
        errs = error_count - start_errors;
        if (errs == 0) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: FAILED with %0d errors", name, errs);
            failed_tests++;
        end
    endtask

    task automatic fill_operands();
        for (int w = 0; w < NUM_BEATS; w++) begin
            for (int s = 0; s < COEFF_PER_CLK; s++) begin
                mem_a[BASE_A + w].slot[s] = {1'b0, rand_coeff()};
                mem_b[BASE_B + w].slot[s] = {1'b0, rand_coeff()};
                mem_c[BASE_C + w].slot[s] = {1'b0, rand_coeff()};
            end
        end
    endtask

    task automatic set_slot(input int w, input int s, input coeff_t a, input coeff_t b,
                            input coeff_t c);
        mem_a[BASE_A + w].slot[s] = {1'b0, a};
        mem_b[BASE_B + w].slot[s] = {1'b0, b};
        mem_c[BASE_C + w].slot[s] = {1'b0, c};
    endtask

    task automatic drive_start(input pwo_mode_e m, input logic acc);
        mem_c_old  = mem_c;
        start      = 1'b1;
        mode       = m;
        accumulate = acc;
        base_a     = BASE_A;
        base_b     = BASE_B;
        base_c     = BASE_C;
    endtask

    // Start one operation, wait for done and count the c reads
    task automatic run_op(input pwo_mode_e m, input logic acc);
        int cycles;
        int c_reads_start;
        int exp_c_reads;
        c_reads_start = rd_c_count;
        // c is read back only for an accumulating multiply
        exp_c_reads   = (m == mode_pwm && acc) ? NUM_BEATS : 0;
        drive_start(m, acc);
        @(negedge clk);
        start  = 1'b0;
        cycles = 1;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("Timed out after %0d cycles waiting for done_o", cycles);
            error_count++;
        end
        @(negedge clk);
        if (rd_c_count - c_reads_start != exp_c_reads) begin
            report_error($sformatf("rd_c_req_o enabled for %0d beats, expected %0d",
                                   rd_c_count - c_reads_start, exp_c_reads));
        end
    endtask

    task automatic check_results(input pwo_mode_e m, input logic acc);
        slot_t  got;
        coeff_t exp;
        for (int w = 0; w < NUM_BEATS; w++) begin
            for (int s = 0; s < COEFF_PER_CLK; s++) begin
                got = mem_c[BASE_C + w].slot[s];
                exp = expected_coeff(m, acc, mem_a[BASE_A + w].slot[s].coeff,
                                     mem_b[BASE_B + w].slot[s].coeff,
                                     mem_c_old[BASE_C + w].slot[s].coeff);
                if (got.coeff !== exp || got.pad !== 1'b0) begin
                    report_error($sformatf("word %0d slot %0d: got %0d pad %b, expected %0d",
                                           w, s, got.coeff, got.pad, exp));
                end
            end
        end
    endtask

    // ==================================================
    // Directed tests
    // ==================================================

    task automatic test_pwm_plain();
        int start_errors;
        start_errors = error_count;
        if (busy !== 1'b0 || done !== 1'b0) begin
            report_error("busy_o or done_o high after reset");
        end
        if (rd_a_req.en !== 1'b0 || rd_b_req.en !== 1'b0 || rd_c_req.en !== 1'b0
            || wr_req.en !== 1'b0) begin
            report_error("request enable high after reset");
        end
        fill_operands();
        run_op(mode_pwm, 1'b0);
        check_results(mode_pwm, 1'b0);
        finish_test("1 multiply", start_errors);
    endtask

    task automatic test_pwm_acc();
        int start_errors;
        start_errors = error_count;
        fill_operands();
        set_slot(0, 0, MLDSA_Q - 1, MLDSA_Q - 1, 23'd5);
        set_slot(1, 2, MLDSA_Q - 1, MLDSA_Q - 1, MLDSA_Q - 1);
        set_slot(63, 3, MLDSA_Q - 1, 23'd2, MLDSA_Q - 1);
        run_op(mode_pwm, 1'b1);
        check_results(mode_pwm, 1'b1);
        finish_test("2 multiply accumulate", start_errors);
    endtask

    task automatic test_add();
        int start_errors;
        start_errors = error_count;
        fill_operands();
        set_slot(0, 0, MLDSA_Q - 1, MLDSA_Q - 1, 23'd0);
        // Sum lands exactly on q
        set_slot(0, 1, MLDSA_Q - 1, 23'd1, 23'd0);
        set_slot(5, 3, 23'd0, 23'd0, 23'd0);
        run_op(mode_pwa, 1'b0);
        check_results(mode_pwa, 1'b0);
        finish_test("3 add", start_errors);
    endtask

    task automatic test_sub();
        int start_errors;
        start_errors = error_count;
        fill_operands();
        set_slot(0, 0, 23'd0, MLDSA_Q - 1, 23'd0);
        set_slot(0, 1, 23'd12345, 23'd12345, 23'd0);
        set_slot(2, 3, 23'd1, 23'd2, 23'd0);
        run_op(mode_pws, 1'b0);
        check_results(mode_pws, 1'b0);
        finish_test("4 subtract", start_errors);
    endtask

    task automatic test_timing();
        int   start_errors;
        int   done_count;
        int   write_count;
        logic exp_busy;
        start_errors = error_count;
        done_count   = 0;
        write_count  = 0;
        fill_operands();
        drive_start(mode_pwa, 1'b0);
        for (int cycle = 1; cycle <= OP_CYCLES + 20; cycle++) begin
            @(negedge clk);
            exp_busy = (cycle < OP_CYCLES);
            if (busy !== exp_busy) begin
                report_error($sformatf("cycle %0d: busy_o %b, expected %b", cycle, busy, exp_busy));
            end
            if (done === 1'b1) begin
                done_count++;
                if (cycle != OP_CYCLES) begin
                    report_error($sformatf("done_o in cycle %0d, expected %0d", cycle, OP_CYCLES));
                end
            end
            if (wr_req.en === 1'b1) begin
                write_count++;
                if (cycle < 4 || cycle > OP_CYCLES - 1 || wr_req.addr != BASE_C + 8'(cycle - 4)) begin
                    report_error($sformatf("cycle %0d: write to address %0d", cycle, wr_req.addr));
                end
            end
            // Second start lands in the middle of the operation
            start = (cycle == 10);
        end
        if (done_count != 1) begin
            report_error($sformatf("%0d done pulses, expected 1", done_count));
        end
        if (write_count != NUM_BEATS) begin
            report_error($sformatf("%0d writes, expected %0d", write_count, NUM_BEATS));
        end
        check_results(mode_pwa, 1'b0);
        finish_test("5 timing", start_errors);
    endtask

    // ==================================================
    // Main sequence and watchdog
    // ==================================================

    initial begin
        reset_n    = 1'b0;
        start      = 1'b0;
        mode       = mode_pwm;
        accumulate = 1'b0;
        base_a     = '0;
        base_b     = '0;
        base_c     = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        test_pwm_plain();
        test_pwm_acc();
        test_add();
        test_sub();
        test_timing();
        $display("Summary: %0d tests, %0d failed, %0d errors",
                 NUM_TESTS, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- sim.f
common/pwo_pkg.sv
verilog/pwo_delay.sv
pwo/pwo_lane.sv
pwo/pwo_ctrl.sv
verilog/pwo_top.sv
test/pwo_asserts.sv
test/pwo_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the pointwise engine testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -Wno-fatal --top-module pwo_tb -f sim.f -o pwo_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/pwo_sim > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log

grep -qx "Testbench passed" sim.log && echo "Simulation PASSED" && exit 0 \
    || { echo "Simulation FAILED"; exit 1; }
